// ==== source/exc_macros.svh ====
/*
  exception unit constants
  debug stop register bit positions, exception vector selector codes
  and the layout of the vector table in the fetch address space
*/

`ifndef EXC_MACROS_SVH
`define EXC_MACROS_SVH

//////////////////////////////////////////////////////////////////////////////
// debug stop register bits
//////////////////////////////////////////////////////////////////////////////
`define DSR_IIE   0  // illegal instruction goes to debug
`define DSR_INTE  1  // interrupt goes to debug

//////////////////////////////////////////////////////////////////////////////
// vector selector codes
//////////////////////////////////////////////////////////////////////////////
`define EXC_PC_NO_INCR  2'd0  // no exception redirect
`define EXC_PC_ILLINSN  2'd1  // illegal instruction handler
`define EXC_PC_IRQ      2'd2  // maskable interrupt handler
`define EXC_PC_IRQ_NM   2'd3  // non-maskable interrupt handler

//////////////////////////////////////////////////////////////////////////////
// vector table layout
//////////////////////////////////////////////////////////////////////////////
`define EXC_VEC_BASE    32'h0000_0100  // first table entry
`define EXC_VEC_STRIDE  32'd8          // bytes between entries

`endif

// ==== source/exc_pkg.sv ====
/*
  exception unit types
  shared vector widths for program counters, vector selectors,
  jump kinds and the debug stop register, plus the state decode
  used by the exception controller
*/

package exc_pkg;

  // 32 bit fetch address
  typedef logic [31:0] pc_t;

  // index into the exception vector table
  typedef logic [1:0] exc_vec_sel_t;

  // jump kind of an in-flight instruction, zero means no jump
  typedef logic [1:0] jump_t;

  // debug stop register, iie and inte bits
  typedef logic [1:0] dsr_t;

  // exception reason picked by the decoder
  typedef enum logic [1:0]
  {
    exc_none,     // nothing to do this cycle
    exc_irq,      // interrupt taken
    exc_illinsn   // illegal instruction or stray rfe
  } exc_reason_e;

endpackage

// ==== source/exc_controller.sv ====
/*
  exception controller
  decodes illegal instructions, interrupts and rfe into one exception
  reason per cycle, blocks nesting with a running flag and drives the
  pc redirect, vector selector and epcr save strobes
  events masked by the debug stop register go out as a trap instead
*/

`timescale 1ns/1ps

`include "exc_macros.svh"

module exc_controller
(
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 fetch_enable_i,       // core may keep fetching

  // interrupt lines
  input  logic                 irq_i,                // level, maskable
  input  logic                 irq_nm_i,             // level, non-maskable
  input  logic                 irq_enable_i,         // global enable

  // pipeline status
  input  logic                 core_busy_i,
  input  exc_pkg::jump_t       jump_in_id_i,         // jump waiting in id
  input  exc_pkg::jump_t       jump_in_ex_i,         // jump waiting in ex
  input  logic                 illegal_insn_i,       // from decoder
  input  logic                 trap_insn_i,          // software trap in id
  input  logic                 clear_isr_running_i,  // rfe strobe

  // debug side
  input  logic                 dbg_flush_pipe_i,     // halt request
  input  logic                 dbg_st_en_i,          // single step mode
  input  exc_pkg::dsr_t        dsr_i,

  // towards fetch
  output logic                 exc_pc_sel_o,         // take exception pc
  output exc_pkg::exc_vec_sel_t exc_vec_sel_o,
  output logic                 save_pc_if_o,         // epcr <= if pc
  output logic                 save_pc_id_o,         // epcr <= id pc

  output logic                 hwloop_enable_o,
  output logic                 irq_present_o,
  output logic                 exc_pipe_flush_o,     // rfe with fetch off
  output logic                 trap_hit_o
);

  exc_pkg::exc_reason_e exc_reason;

  logic running_q;  // inside a handler
  logic running_d;
  logic no_jump;    // both jump slots empty

  assign irq_present_o   = (irq_i | irq_nm_i) & irq_enable_i;
  assign hwloop_enable_o = ~core_busy_i;  // hw loops only while idle

  assign no_jump = (jump_in_id_i == '0) && (jump_in_ex_i == '0);

  ////////////////////////////////////////////////////////////////////////////
  // trap towards debug
  ////////////////////////////////////////////////////////////////////////////

  // software trap, halt request, single step, or an exception
  // that the dsr hands over to the debug side
  assign trap_hit_o = trap_insn_i
                    | dbg_flush_pipe_i
                    | dbg_st_en_i
                    | (illegal_insn_i & dsr_i[`DSR_IIE])
                    | (irq_present_o & dsr_i[`DSR_INTE] & ~running_q);

  ////////////////////////////////////////////////////////////////////////////
  // reason decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    exc_reason       = exc_pkg::exc_none;
    exc_pipe_flush_o = 1'b0;

    if (illegal_insn_i)
    begin
      // no handler entry while one is running
      if (!dsr_i[`DSR_IIE] && !running_q)
        exc_reason = exc_pkg::exc_illinsn;
    end
    else if (irq_present_o && !running_q)
    begin
      if (!dsr_i[`DSR_INTE])
        exc_reason = exc_pkg::exc_irq;
    end
    else if (clear_isr_running_i)
    begin
      if (running_q)
        exc_pipe_flush_o = ~fetch_enable_i;  // core goes back to sleep
      else
        exc_reason = exc_pkg::exc_illinsn;   // rfe outside a handler
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // redirect fsm
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    running_d     = running_q;
    exc_pc_sel_o  = 1'b0;
    exc_vec_sel_o = `EXC_PC_NO_INCR;
    save_pc_if_o  = 1'b0;
    save_pc_id_o  = 1'b0;

    unique case (exc_reason)
      exc_pkg::exc_irq:
      begin
        // let pending jumps resolve first, retried every cycle
        if (no_jump)
        begin
          exc_pc_sel_o  = 1'b1;
          save_pc_if_o  = 1'b1;  // return to the fetched insn
          exc_vec_sel_o = irq_nm_i ? `EXC_PC_IRQ_NM : `EXC_PC_IRQ;
          running_d     = 1'b1;
        end
      end
      exc_pkg::exc_illinsn:
      begin
        exc_pc_sel_o  = 1'b1;
        save_pc_id_o  = 1'b1;    // return to the faulting insn
        exc_vec_sel_o = `EXC_PC_ILLINSN;
        running_d     = 1'b1;
      end
      default:
      begin
        running_d = running_q;
      end
    endcase
  end

  // running flag, rfe wins over a new entry
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      running_q <= 1'b0;
    else if (clear_isr_running_i)
      running_q <= 1'b0;
    else
      running_q <= running_d;
  end

endmodule

// ==== source/exc_pc_unit.sv ====
/*
  exception pc unit
  turns the vector selector into a fetch address inside the vector
  table and keeps the exception pc register, loaded from the if or
  id stage pc when the controller enters a handler
*/

`timescale 1ns/1ps

`include "exc_macros.svh"

module exc_pc_unit
(
  input  logic                  clk,
  input  logic                  rst_n,

  // from the exception controller
  input  exc_pkg::exc_vec_sel_t exc_vec_sel_i,  // table index
  input  logic                  save_pc_if_i,   // interrupt entry
  input  logic                  save_pc_id_i,   // illegal insn entry

  // stage pcs
  input  exc_pkg::pc_t          pc_if_i,
  input  exc_pkg::pc_t          pc_id_i,

  output exc_pkg::pc_t          exc_pc_o,       // handler address
  output exc_pkg::pc_t          epcr_o          // return address
);

  exc_pkg::pc_t vec_offset;  // byte offset into the table
  exc_pkg::pc_t epcr_q;

  ////////////////////////////////////////////////////////////////////////////
  // vector address
  ////////////////////////////////////////////////////////////////////////////

  // selector scaled by the entry stride, widened to a full pc first
  assign vec_offset = exc_pkg::pc_t'(exc_vec_sel_i) * `EXC_VEC_STRIDE;

  // same cycle as the selector, no register on this path
  assign exc_pc_o = `EXC_VEC_BASE + vec_offset;

  ////////////////////////////////////////////////////////////////////////////
  // exception pc register
  ////////////////////////////////////////////////////////////////////////////

  // the controller never raises both strobes in one cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      epcr_q <= '0;
    end
    else if (save_pc_if_i)
    begin
      epcr_q <= pc_if_i;  // interrupt, resume at fetched insn
    end
    else if (save_pc_id_i)
    begin
      epcr_q <= pc_id_i;  // illegal insn, point at the culprit
    end
  end

  assign epcr_o = epcr_q;  // visible one cycle after the strobe

endmodule

// ==== source/debug_stop_unit.sv ====
/*
  debug stop unit
  holds the debug stop register written by the debug port and a
  sticky halted flag, set by a trap from the exception controller
  and cleared by a resume request
*/

`timescale 1ns/1ps

`include "exc_macros.svh"

module debug_stop_unit
(
  input  logic          clk,
  input  logic          rst_n,

  // debug port
  input  logic          dsr_we_i,     // write strobe
  input  exc_pkg::dsr_t dsr_wdata_i,
  input  logic          resume_i,     // leave halt

  input  logic          trap_hit_i,   // from the exception controller

  output exc_pkg::dsr_t dsr_o,
  output logic          halted_o
);

  exc_pkg::dsr_t dsr_q;
  logic          halted_q;

  ////////////////////////////////////////////////////////////////////////////
  // debug stop register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dsr_q <= '0;
    end
    else if (dsr_we_i)
    begin
      dsr_q[`DSR_IIE]  <= dsr_wdata_i[`DSR_IIE];   // illegal insn stop
      dsr_q[`DSR_INTE] <= dsr_wdata_i[`DSR_INTE];  // interrupt stop
    end
  end

  assign dsr_o = dsr_q;

  ////////////////////////////////////////////////////////////////////////////
  // halted flag
  ////////////////////////////////////////////////////////////////////////////

  // a trap in the same cycle as a resume keeps the core halted
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      halted_q <= 1'b0;
    else if (trap_hit_i)
      halted_q <= 1'b1;
    else if (resume_i)
      halted_q <= 1'b0;
  end

  assign halted_o = halted_q;

endmodule

// ==== source/exc_unit_top.sv ====
/*
  exception unit top
  exception controller, exception pc unit and debug stop unit of a
  small pipelined core, with fetch, decode and debug transport
  signals brought out as plain ports
*/

`timescale 1ns/1ps

module exc_unit_top
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  fetch_enable_i,
  input  logic                  irq_i,
  input  logic                  irq_nm_i,
  input  logic                  irq_enable_i,
  input  logic                  core_busy_i,

  // pipeline status
  input  exc_pkg::jump_t        jump_in_id_i,
  input  exc_pkg::jump_t        jump_in_ex_i,
  input  logic                  illegal_insn_i,
  input  logic                  trap_insn_i,
  input  logic                  clear_isr_running_i,  // rfe
  input  exc_pkg::pc_t          pc_if_i,
  input  exc_pkg::pc_t          pc_id_i,

  // debug port
  input  logic                  dbg_flush_pipe_i,
  input  logic                  dbg_st_en_i,
  input  logic                  dbg_dsr_we_i,
  input  exc_pkg::dsr_t         dbg_dsr_wdata_i,
  input  logic                  dbg_resume_i,

  output logic                  exc_pc_sel_o,
  output exc_pkg::pc_t          exc_pc_o,
  output exc_pkg::pc_t          epcr_o,
  output logic                  hwloop_enable_o,
  output logic                  irq_present_o,
  output logic                  exc_pipe_flush_o,
  output logic                  trap_hit_o,
  output logic                  dbg_halted_o,
  output exc_pkg::dsr_t         dsr_o
);

  exc_pkg::exc_vec_sel_t exc_vec_sel;  // controller to pc unit
  logic                  save_pc_if;
  logic                  save_pc_id;

  ////////////////////////////////////////////////////////////////////////////
  // exception controller
  ////////////////////////////////////////////////////////////////////////////

  exc_controller u_exc_controller
  (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable_i),
    .irq_i               (irq_i),
    .irq_nm_i            (irq_nm_i),
    .irq_enable_i        (irq_enable_i),
    .core_busy_i         (core_busy_i),
    .jump_in_id_i        (jump_in_id_i),
    .jump_in_ex_i        (jump_in_ex_i),
    .illegal_insn_i      (illegal_insn_i),
    .trap_insn_i         (trap_insn_i),
    .clear_isr_running_i (clear_isr_running_i),
    .dbg_flush_pipe_i    (dbg_flush_pipe_i),
    .dbg_st_en_i         (dbg_st_en_i),
    .dsr_i               (dsr_o),         // from the debug stop unit
    .exc_pc_sel_o        (exc_pc_sel_o),
    .exc_vec_sel_o       (exc_vec_sel),
    .save_pc_if_o        (save_pc_if),
    .save_pc_id_o        (save_pc_id),
    .hwloop_enable_o     (hwloop_enable_o),
    .irq_present_o       (irq_present_o),
    .exc_pipe_flush_o    (exc_pipe_flush_o),
    .trap_hit_o          (trap_hit_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // vector address and epcr
  ////////////////////////////////////////////////////////////////////////////

  exc_pc_unit u_exc_pc_unit
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .exc_vec_sel_i (exc_vec_sel),
    .save_pc_if_i  (save_pc_if),
    .save_pc_id_i  (save_pc_id),
    .pc_if_i       (pc_if_i),
    .pc_id_i       (pc_id_i),
    .exc_pc_o      (exc_pc_o),
    .epcr_o        (epcr_o)
  );

  // dsr and halt state
  debug_stop_unit u_debug_stop_unit
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .dsr_we_i    (dbg_dsr_we_i),
    .dsr_wdata_i (dbg_dsr_wdata_i),
    .resume_i    (dbg_resume_i),
    .trap_hit_i  (trap_hit_o),  // trap from the controller
    .dsr_o       (dsr_o),
    .halted_o    (dbg_halted_o)
  );

endmodule

// ==== tests/exc_tb.sv ====
/*
  exception unit testbench
  directed runs for illegal instructions, interrupts, rfe, debug stops
  and hardware loop enable, then a random run, all checked every cycle
  against a reference model of the exception unit
*/

`timescale 1ns/1ps

`include "exc_macros.svh"

module exc_tb;

  localparam int clk_half    = 20;   // 40 ns period
  localparam int test_cycles = 500;  // reset, directed runs and random run
  localparam int margin      = 200;

  logic clk, rst_n;
  logic fetch_enable, irq, irq_nm, irq_enable, core_busy;
  logic illegal_insn, trap_insn, rfe;
  logic dbg_flush, dbg_st_en, dbg_dsr_we, dbg_resume;
  exc_pkg::jump_t jump_in_id, jump_in_ex;
  exc_pkg::pc_t   pc_if, pc_id;
  exc_pkg::dsr_t  dbg_dsr_wdata;

  logic exc_pc_sel, hwloop_enable, irq_present, pipe_flush, trap_hit, halted;
  exc_pkg::pc_t  exc_pc, epcr;
  exc_pkg::dsr_t dsr;

  // reference model state and expected values
  logic m_running, m_halted;
  exc_pkg::pc_t m_epcr;
  exc_pkg::dsr_t m_dsr;
  logic e_pc_sel, e_save_if, e_save_id, e_flush, e_trap, e_irq_present;
  exc_pkg::exc_vec_sel_t e_vec_sel;

  int errors = 0;
  int err_mark = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  logic [31:0] rnd;

  exc_unit_top dut
  (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .irq_i (irq), .irq_nm_i (irq_nm),
    .irq_enable_i (irq_enable), .core_busy_i (core_busy),
    .jump_in_id_i (jump_in_id), .jump_in_ex_i (jump_in_ex),
    .illegal_insn_i (illegal_insn), .trap_insn_i (trap_insn),
    .clear_isr_running_i (rfe), .pc_if_i (pc_if), .pc_id_i (pc_id),
    .dbg_flush_pipe_i (dbg_flush), .dbg_st_en_i (dbg_st_en),
    .dbg_dsr_we_i (dbg_dsr_we), .dbg_dsr_wdata_i (dbg_dsr_wdata),
    .dbg_resume_i (dbg_resume),
    .exc_pc_sel_o (exc_pc_sel), .exc_pc_o (exc_pc), .epcr_o (epcr),
    .hwloop_enable_o (hwloop_enable), .irq_present_o (irq_present),
    .exc_pipe_flush_o (pipe_flush), .trap_hit_o (trap_hit),
    .dbg_halted_o (halted), .dsr_o (dsr)
  );

  initial clk = 1'b0;
  always #clk_half clk = ~clk;

  //////////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // handler address for a selector code
  function automatic exc_pkg::pc_t vector_addr(input exc_pkg::exc_vec_sel_t sel);
    return `EXC_VEC_BASE + exc_pkg::pc_t'(sel) * `EXC_VEC_STRIDE;
  endfunction

  // expected strobes for the current inputs and model state
  function automatic void predict();
    exc_pkg::exc_reason_e reason;
    reason        = exc_pkg::exc_none;
    e_irq_present = (irq | irq_nm) & irq_enable;
    e_flush       = 1'b0;
    e_pc_sel      = 1'b0;
    e_save_if     = 1'b0;
    e_save_id     = 1'b0;
    e_vec_sel     = `EXC_PC_NO_INCR;
    e_trap = trap_insn | dbg_flush | dbg_st_en | (illegal_insn & m_dsr[`DSR_IIE])
           | (e_irq_present & m_dsr[`DSR_INTE] & ~m_running);
    if (illegal_insn)
      reason = (!m_dsr[`DSR_IIE] && !m_running) ? exc_pkg::exc_illinsn : exc_pkg::exc_none;
    else if (e_irq_present && !m_running)
      reason = m_dsr[`DSR_INTE] ? exc_pkg::exc_none : exc_pkg::exc_irq;
    else if (rfe && m_running)
      e_flush = ~fetch_enable;
    else if (rfe)
      reason = exc_pkg::exc_illinsn;  // stray rfe
    if (reason == exc_pkg::exc_illinsn)
    begin
      e_pc_sel  = 1'b1;
      e_save_id = 1'b1;
      e_vec_sel = `EXC_PC_ILLINSN;
    end
    else if (reason == exc_pkg::exc_irq && jump_in_id == '0 && jump_in_ex == '0)
    begin
      e_pc_sel  = 1'b1;
      e_save_if = 1'b1;
      e_vec_sel = irq_nm ? `EXC_PC_IRQ_NM : `EXC_PC_IRQ;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_pc(input string name, input exc_pkg::pc_t exp,
                          input exc_pkg::pc_t act);
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_sel(input string name, input exc_pkg::exc_vec_sel_t exp,
                           input exc_pkg::exc_vec_sel_t act);
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_dsr(input string name, input exc_pkg::dsr_t exp,
                           input exc_pkg::dsr_t act);
    if (act !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // runs every cycle just ahead of the next rising edge
  always @(posedge clk)
  begin
    #(2 * clk_half - 2);
    if (!rst_n)
    begin
      m_running = 1'b0;
      m_halted  = 1'b0;
      m_epcr    = '0;
      m_dsr     = '0;
    end
    else
    begin
      predict();
      check_bit("exc_pc_sel_o", e_pc_sel, exc_pc_sel);
      check_sel("exc_vec_sel", e_vec_sel, dut.exc_vec_sel);
      check_pc("exc_pc_o", vector_addr(e_vec_sel), exc_pc);
      check_pc("epcr_o", m_epcr, epcr);
      check_bit("hwloop_enable_o", ~core_busy, hwloop_enable);
      check_bit("irq_present_o", e_irq_present, irq_present);
      check_bit("exc_pipe_flush_o", e_flush, pipe_flush);
      check_bit("trap_hit_o", e_trap, trap_hit);
      check_bit("dbg_halted_o", m_halted, halted);
      check_dsr("dsr_o", m_dsr, dsr);
      // state seen after the coming edge
      // rfe beats a new entry
      m_running = rfe ? 1'b0 : (e_pc_sel | m_running);
      m_epcr    = e_save_if ? pc_if : (e_save_id ? pc_id : m_epcr);
      m_dsr     = dbg_dsr_we ? dbg_dsr_wdata : m_dsr;
      m_halted  = e_trap ? 1'b1 : (dbg_resume ? 1'b0 : m_halted);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////////

  task automatic idle();
    fetch_enable  = 1'b1;
    irq           = 1'b0;
    irq_nm        = 1'b0;
    irq_enable    = 1'b1;
    core_busy     = 1'b0;
    jump_in_id    = '0;
    jump_in_ex    = '0;
    illegal_insn  = 1'b0;
    trap_insn     = 1'b0;
    rfe           = 1'b0;
    dbg_flush     = 1'b0;
    dbg_st_en     = 1'b0;
    dbg_dsr_we    = 1'b0;
    dbg_dsr_wdata = '0;
    dbg_resume    = 1'b0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;  // inputs change shortly after the edge
  endtask

  task automatic settle();
    #30;
  endtask

  task automatic finish_test(input string name);
    if (errors == err_mark)
    begin
      tests_passed++;
      $display("test %-10s ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %-10s %0d mismatches", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic drive_random();
    rnd          = xorshift(rnd);
    irq          = rnd[0];
    irq_nm       = rnd[1] & rnd[2];
    irq_enable   = rnd[3] | rnd[4];
    core_busy    = rnd[5];
    jump_in_id   = rnd[7:6] & {2{rnd[8]}};
    jump_in_ex   = rnd[10:9] & {2{rnd[11]}};
    illegal_insn = rnd[12] & rnd[13];
    rfe          = ~illegal_insn & rnd[14] & rnd[15];  // never with illegal
    trap_insn    = (rnd[19:16] == 4'd0);
    dbg_flush    = (rnd[23:20] == 4'd0);
    dbg_st_en    = (rnd[27:24] == 4'd0);
    fetch_enable = rnd[28] | rnd[29];
    dbg_dsr_we   = (rnd[31:29] == 3'd0);
    dbg_resume   = rnd[26] & rnd[25];
    rnd           = xorshift(rnd);
    pc_if         = {rnd[31:2], 2'b00};
    pc_id         = pc_if - 32'd4;
    dbg_dsr_wdata = rnd[1:0];  // low bits unused by the word aligned pc
  endtask

  //////////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n = 1'b0;
    rnd   = 32'd39;
    pc_if = '0;
    pc_id = '0;
    idle();
    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;

    // illegal instruction then a blocked nested one
    pc_id        = 32'h2000_0010;
    pc_if        = 32'h2000_0014;
    illegal_insn = 1'b1;
    settle();
    check_bit("exc_pc_sel_o", 1'b1, exc_pc_sel);
    check_pc("exc_pc_o", `EXC_VEC_BASE + `EXC_PC_ILLINSN * `EXC_VEC_STRIDE, exc_pc);
    next_cycle();
    illegal_insn = 1'b0;
    settle();
    check_pc("epcr_o", 32'h2000_0010, epcr);
    next_cycle();
    illegal_insn = 1'b1;
    settle();
    check_bit("exc_pc_sel_o", 1'b0, exc_pc_sel);
    next_cycle();
    illegal_insn = 1'b0;
    rfe          = 1'b1;
    next_cycle();
    idle();
    finish_test("illegal");

    // interrupt held off by jumps, nm over maskable, masked by enable
    irq        = 1'b1;
    jump_in_id = 2'd1;
    pc_if      = 32'h0000_4a00;
    repeat (3) next_cycle();
    jump_in_id = '0;
    jump_in_ex = 2'd2;
    settle();
    check_bit("exc_pc_sel_o", 1'b0, exc_pc_sel);
    repeat (2) next_cycle();
    jump_in_ex = '0;
    irq_nm     = 1'b1;
    settle();
    check_sel("exc_vec_sel", `EXC_PC_IRQ_NM, dut.exc_vec_sel);
    next_cycle();
    irq    = 1'b0;
    irq_nm = 1'b0;
    settle();
    check_pc("epcr_o", 32'h0000_4a00, epcr);
    next_cycle();
    rfe = 1'b1;
    next_cycle();
    rfe        = 1'b0;
    irq_enable = 1'b0;
    irq        = 1'b1;
    settle();
    check_bit("irq_present_o", 1'b0, irq_present);
    repeat (2) next_cycle();
    irq_enable = 1'b1;
    settle();
    check_sel("exc_vec_sel", `EXC_PC_IRQ, dut.exc_vec_sel);
    next_cycle();
    irq = 1'b0;
    rfe = 1'b1;
    next_cycle();
    idle();
    finish_test("interrupt");

    // rfe with fetch off, unblocking, and a stray rfe
    illegal_insn = 1'b1;
    next_cycle();
    illegal_insn = 1'b0;
    rfe          = 1'b1;
    fetch_enable = 1'b0;
    settle();
    check_bit("exc_pipe_flush_o", 1'b1, pipe_flush);
    next_cycle();
    rfe          = 1'b0;
    fetch_enable = 1'b1;
    illegal_insn = 1'b1;
    settle();
    check_bit("exc_pc_sel_o", 1'b1, exc_pc_sel);
    next_cycle();
    illegal_insn = 1'b0;
    rfe          = 1'b1;
    next_cycle();
    settle();
    check_sel("exc_vec_sel", `EXC_PC_ILLINSN, dut.exc_vec_sel);
    next_cycle();
    idle();
    finish_test("rfe");

    // debug stop bits turn events into traps, then halt and resume
    dbg_dsr_we    = 1'b1;
    dbg_dsr_wdata = 2'b11;
    next_cycle();
    dbg_dsr_we   = 1'b0;
    illegal_insn = 1'b1;
    settle();
    check_bit("trap_hit_o", 1'b1, trap_hit);
    next_cycle();
    illegal_insn = 1'b0;
    settle();
    check_bit("dbg_halted_o", 1'b1, halted);
    next_cycle();
    dbg_resume = 1'b1;
    next_cycle();
    dbg_resume = 1'b0;
    irq        = 1'b1;
    settle();
    check_bit("dbg_halted_o", 1'b0, halted);
    next_cycle();
    irq        = 1'b0;
    dbg_resume = 1'b1;
    next_cycle();
    dbg_resume = 1'b0;
    trap_insn  = 1'b1;
    settle();
    check_bit("trap_hit_o", 1'b1, trap_hit);
    next_cycle();
    trap_insn = 1'b0;
    dbg_flush = 1'b1;
    settle();
    check_bit("trap_hit_o", 1'b1, trap_hit);
    next_cycle();
    dbg_flush = 1'b0;
    dbg_st_en = 1'b1;
    settle();
    check_bit("trap_hit_o", 1'b1, trap_hit);
    next_cycle();
    dbg_st_en     = 1'b0;
    dbg_resume    = 1'b1;
    dbg_dsr_we    = 1'b1;
    dbg_dsr_wdata = '0;  // stop bits off again
    next_cycle();
    idle();
    finish_test("debug");

    // hw loop enable follows core busy
    repeat (4)
    begin
      core_busy = ~core_busy;
      settle();
      check_bit("hwloop_enable_o", ~core_busy, hwloop_enable);
      next_cycle();
    end
    idle();
    finish_test("hwloop");

    // random run
    repeat (400)
    begin
      drive_random();
      next_cycle();
    end
    idle();
    next_cycle();
    finish_test("random");

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // ends a stuck run
  initial
  begin
    #((test_cycles + margin) * 2 * clk_half);
    $display("timeout: the run did not finish within %0d cycles", test_cycles + margin);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+source
source/exc_pkg.sv
source/exc_controller.sv
source/exc_pc_unit.sv
source/debug_stop_unit.sv
source/exc_unit_top.sv
tests/exc_tb.sv
